// File: src.f
cpu_isa_pkg.sv
cpu_pipe_pkg.sv
stage_if.sv
cpu_fetch.sv
cpu_decode.sv
cpu_regfile.sv
cpu_execute.sv
cpu_core.sv
cpu_checker.sv
tb_cpu.sv

// File: run.sh
#!/bin/sh
# Build the core testbench with Verilator, run it, then search the log
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_cpu -f src.f -o tb_cpu_sim &&
    ./obj_dir/tb_cpu_sim > sim.log 2>&1 ||
    { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "^ALL CHECKS PASSED$" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }

// File: tb_cpu.sv
/*
 * Testbench for the three-stage RV32I core
 * Builds a random program from a fixed skeleton and models the instruction
 * memory with a random response latency
 */
module tb_cpu
    import cpu_isa_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // Program length in words out of a 32-word image
    localparam int              N          = 27;
    localparam logic [XLEN-1:0] PROG_BYTES = XLEN'(N * 4);
    localparam int              LIMIT      = N * 12 + 50;

    logic              clk;
    logic              rst_n;
    logic              imem_req;
    logic [XLEN-1:0]   imem_addr;
    logic              imem_valid = 1'b0;
    logic [XLEN-1:0]   imem_rdata = '0;
    logic              imem_err   = 1'b0;
    logic              retire_valid;
    logic [XLEN-1:0]   retire_pc;
    logic [REG_AW-1:0] retire_rd;
    logic [XLEN-1:0]   retire_wdata;
    logic              retire_trap;
    logic              busy;
    logic              done;
    int                retired;
    int                mismatches;
    int                other_errors;
    logic [XLEN-1:0]   prog [0:31];
    // Memory model state
    logic              mem_busy = 1'b0;
    int unsigned       mem_wait = 0;
    logic [XLEN-1:0]   mem_addr = '0;
    int                cycles;
    logic              timed_out;

    cpu_core dut (
        .clk, .rst_n, .imem_req, .imem_addr, .imem_valid, .imem_rdata, .imem_err,
        .retire_valid, .retire_pc, .retire_rd, .retire_wdata, .retire_trap, .busy
    );

    cpu_checker #(.N(N)) u_check (
        .clk, .rst_n, .prog, .imem_req, .busy,
        .retire_valid, .retire_pc, .retire_rd, .retire_wdata, .retire_trap,
        .done, .retired, .mismatches, .other_errors
    );

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] itype(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] utype(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    // Offset in bytes with bit 0 dropped by the format
    function automatic logic [31:0] btype(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jtype(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // Random register other than x0 and not yet in use
    function automatic logic [4:0] pick_reg(inout logic [31:0] used);
        logic [4:0] r;
        do r = 5'($urandom_range(31, 1)); while (used[r]);
        used[r] = 1'b1;
        return r;
    endfunction

    task automatic build_program();
        logic [31:0] used;
        logic [4:0]  ra, rb, rc, rd;
        used = 32'h1;
        ra   = pick_reg(used);
        rb   = pick_reg(used);
        rc   = pick_reg(used);
        rd   = pick_reg(used);
        // Unused words carry an address pattern
        for (int i = 0; i < 32; i++) begin
            prog[i] = 32'(i * 4) ^ 32'hbadc_0ffe;
        end
        // Dependent ALU chain where every result feeds the next one
        prog[0]  = itype(F3_ADD, ra, 5'd0, 12'($urandom));
        prog[1]  = itype(F3_ADD, rb, ra, 12'($urandom));
        prog[2]  = rtype(7'd0, F3_ADD, rc, ra, rb);
        prog[3]  = rtype(F7_SUB, F3_ADD, rd, rc, ra);
        prog[4]  = itype(F3_XOR, ra, rd, 12'($urandom));
        prog[5]  = itype(F3_OR, rb, ra, 12'($urandom));
        prog[6]  = itype(F3_AND, rc, rb, 12'($urandom));
        prog[7]  = rtype(7'd0, F3_XOR, rd, rc, rb);
        prog[8]  = rtype(7'd0, F3_OR, ra, rd, rc);
        prog[9]  = rtype(7'd0, F3_AND, rb, ra, rd);
        prog[10] = utype(rc, 20'($urandom));
        // Write to x0 is dropped so the read back sees zero
        prog[11] = itype(F3_ADD, 5'd0, rc, 12'($urandom));
        prog[12] = rtype(7'd0, F3_ADD, rd, 5'd0, rc);
        // Taken branches skip one wrong-path word
        prog[13] = btype(F3_BEQ, rd, rc, 13'd8);
        prog[14] = itype(F3_ADD, ra, 5'd0, 12'd1);
        prog[15] = btype(F3_BNE, rd, rc, 13'd8);
        prog[16] = itype(F3_ADD, rb, rd, 12'd1);
        prog[17] = btype(F3_BNE, rb, rd, 13'd8);
        prog[18] = itype(F3_ADD, rc, 5'd0, 12'd5);
        prog[19] = btype(F3_BEQ, rb, rd, 13'd8);
        // Jump over two words and use the link right after
        prog[20] = jtype(ra, 21'd12);
        prog[21] = itype(F3_ADD, rd, 5'd0, 12'd7);
        prog[22] = utype(rd, 20'($urandom));
        prog[23] = rtype(7'd0, F3_ADD, rb, ra, rb);
        // Multiply encoding and an all-zero word both trap
        prog[24] = rtype(7'b0000001, F3_ADD, rb, ra, rb);
        prog[25] = 32'h0000_0000;
        prog[26] = itype(F3_ADD, rc, rb, 12'($urandom));
    endtask

    // One response cycle with a fault past the program
    task automatic answer(input logic [XLEN-1:0] addr);
        imem_valid = 1'b1;
        if (addr < PROG_BYTES) begin
            imem_rdata = prog[addr[6:2]];
            imem_err   = 1'b0;
        end else begin
            imem_rdata = addr ^ 32'hbadc_0ffe;
            imem_err   = 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Instruction memory with 0 to 3 cycles of latency
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        imem_valid = 1'b0;
        if (mem_busy) begin
            if (mem_wait == 0) begin
                answer(mem_addr);
                mem_busy = 1'b0;
            end else begin
                mem_wait--;
            end
        end else if (rst_n && imem_req) begin
            mem_addr = imem_addr;
            mem_wait = $urandom_range(3, 0);
            if (mem_wait == 0) begin
                answer(mem_addr);
            end else begin
                mem_wait--;
                mem_busy = 1'b1;
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst_n     = 1'b0;
        timed_out = 1'b0;
        cycles    = 0;
        void'($urandom(32'hc9f2_aac7));
        build_program();
        // Five rising edges in reset, release on the falling edge after
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // Run until the checker has seen the whole program
        while (!done && cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            $display("Error: run ended before the program finished");
            timed_out = 1'b1;
        end
        $display("Summary: %0d retired, %0d mismatches, %0d other errors, %0d cycles",
                 retired, mismatches, other_errors + int'(timed_out), cycles);
        if (mismatches == 0 && other_errors == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: cpu_checker.sv
/*
 * Retire stream checker for the core testbench
 * Steps an architectural model over the program image and compares every
 * retired instruction in order
 */
module cpu_checker
    import cpu_isa_pkg::*;
#(
    parameter int N = 27
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [XLEN-1:0]   prog [0:31],
    input  logic              imem_req,
    input  logic              busy,
    input  logic              retire_valid,
    input  logic [XLEN-1:0]   retire_pc,
    input  logic [REG_AW-1:0] retire_rd,
    input  logic [XLEN-1:0]   retire_wdata,
    input  logic              retire_trap,
    output logic              done,
    output int                retired,
    output int                mismatches,
    output int                other_errors
);
    timeunit 1ns;
    timeprecision 100ps;

    // Expected outcome of one instruction
    typedef struct packed {
        logic [XLEN-1:0]   next_pc;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   wdata;
        logic              trap;
    } step_t;

    localparam logic [XLEN-1:0] PROG_BYTES = XLEN'(N * 4);

    logic [XLEN-1:0] model_regs [0:31];
    logic [XLEN-1:0] model_pc   = '0;
    logic            model_done = 1'b0;
    logic            reset_seen = 1'b0;
    int              n_retired  = 0;
    int              n_mismatch = 0;
    int              n_other    = 0;

    assign done         = model_done;
    assign retired      = n_retired;
    assign mismatches   = n_mismatch;
    assign other_errors = n_other;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model stepping one instruction per call
    ////////////////////////////////////////////////////////////////////////////
    function automatic step_t ref_step(input logic [XLEN-1:0] pc,
                                       input logic [XLEN-1:0] ins, input logic fault);
        step_t           s;
        logic [XLEN-1:0] a, b, imm_i, imm_b, imm_j;
        logic            ok;
        a       = model_regs[ins[19:15]];
        b       = model_regs[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        ok      = 1'b1;
        s.next_pc = pc + 32'd4;
        s.rd      = ins[11:7];
        s.wdata   = '0;
        s.trap    = 1'b0;
        case (ins[6:0])
            OPC_OP_IMM: begin
                case (ins[14:12])
                    F3_ADD:  s.wdata = a + imm_i;
                    F3_XOR:  s.wdata = a ^ imm_i;
                    F3_OR:   s.wdata = a | imm_i;
                    F3_AND:  s.wdata = a & imm_i;
                    default: ok = 1'b0;
                endcase
            end
            OPC_OP: begin
                case ({ins[31:25], ins[14:12]})
                    {7'd0, F3_ADD}:   s.wdata = a + b;
                    {F7_SUB, F3_ADD}: s.wdata = a - b;
                    {7'd0, F3_XOR}:   s.wdata = a ^ b;
                    {7'd0, F3_OR}:    s.wdata = a | b;
                    {7'd0, F3_AND}:   s.wdata = a & b;
                    default:          ok = 1'b0;
                endcase
            end
            OPC_LUI: s.wdata = {ins[31:12], 12'h000};
            OPC_BRANCH: begin
                s.rd = '0;
                case (ins[14:12])
                    F3_BEQ:  if (a == b) s.next_pc = pc + imm_b;
                    F3_BNE:  if (a != b) s.next_pc = pc + imm_b;
                    default: ok = 1'b0;
                endcase
            end
            OPC_JAL: begin
                s.wdata   = pc + 32'd4;
                s.next_pc = pc + imm_j;
            end
            default: ok = 1'b0;
        endcase
        // Trap writes nothing and falls through
        if (fault || !ok) begin
            s.trap    = 1'b1;
            s.rd      = '0;
            s.next_pc = pc + 32'd4;
        end
        if (s.rd == '0) s.wdata = '0;
        return s;
    endfunction

    function automatic string test_name(input logic [XLEN-1:0] ins, input logic fault);
        if (fault) return "fetch_fault";
        case (ins[6:0])
            OPC_OP_IMM, OPC_OP: return "alu";
            OPC_LUI:            return "lui";
            OPC_BRANCH:         return "branch";
            OPC_JAL:            return "jal";
            default:            return "illegal";
        endcase
    endfunction

    task automatic check_field(input string test, input string field,
                               input logic [XLEN-1:0] want, input logic [XLEN-1:0] got);
        if (want !== got) begin
            $display("Mismatch %s %s: expected 0x%08h, actual 0x%08h", test, field, want, got);
            n_mismatch++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) reset_seen <= 1'b1;
    end

    // In-order comparison of each retired instruction against the model
    always @(negedge clk) begin : compare
        logic [XLEN-1:0] ins;
        logic            fault;
        step_t           want;
        string           name;
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) model_regs[i] = '0;
            model_pc = '0;
            if (reset_seen && (retire_valid || imem_req || busy)) begin
                $display("Error: retire_valid, imem_req or busy high during reset");
                n_other++;
            end
        end else if (retire_valid && !model_done) begin
            fault = (model_pc >= PROG_BYTES);
            ins   = fault ? '0 : prog[model_pc[6:2]];
            want  = ref_step(model_pc, ins, fault);
            name  = test_name(ins, fault);
            check_field(name, "pc", model_pc, retire_pc);
            check_field(name, "rd", 32'(want.rd), 32'(retire_rd));
            check_field(name, "wdata", want.wdata, retire_wdata);
            check_field(name, "trap", 32'(want.trap), 32'(retire_trap));
            if (want.rd != '0) model_regs[want.rd] = want.wdata;
            model_pc   = want.next_pc;
            n_retired++;
            model_done = (model_pc > PROG_BYTES);
        end
    end

endmodule

// File: cpu_core.sv
/*
 * Three-stage RV32I core top level
 * Fetch, decode and execute around one register file
 */
module cpu_core
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    // Instruction memory port
    output logic              imem_req,
    output logic [XLEN-1:0]   imem_addr,
    input  logic              imem_valid,
    input  logic [XLEN-1:0]   imem_rdata,
    input  logic              imem_err,
    // Retire port
    output logic              retire_valid,
    output logic [XLEN-1:0]   retire_pc,
    output logic [REG_AW-1:0] retire_rd,
    output logic [XLEN-1:0]   retire_wdata,
    output logic              retire_trap,
    output logic              busy
);

    stage_if #(.payload_t(fetch_pkt_t)) f2d ();
    stage_if #(.payload_t(exec_pkt_t))  d2e ();

    d2f_cmd_t          d2f_cmd;
    logic [XLEN-1:0]   d2f_branchtarget;
    e2d_cmd_t          e2d_cmd;
    logic [XLEN-1:0]   e2d_branchtarget;
    logic              e2d_rd_write;
    logic [REG_AW-1:0] e2d_rd_waddr;
    logic              e2d_busy;
    logic [REG_AW-1:0] rs1_raddr, rs2_raddr;
    logic [XLEN-1:0]   rs1_rdata, rs2_rdata;
    logic              rd_write;
    logic [REG_AW-1:0] rd_waddr;
    logic [XLEN-1:0]   rd_wdata;
    logic              dec_busy;

    // Busy while decode or execute holds work
    assign busy = dec_busy || e2d_busy;

    cpu_fetch u_fetch (
        .clk, .rst_n, .imem_req, .imem_addr, .imem_valid, .imem_rdata, .imem_err,
        .f2d(f2d.sender), .d2f_cmd, .d2f_branchtarget
    );

    cpu_decode u_decode (
        .clk, .rst_n, .busy(dec_busy), .f2d(f2d.receiver), .d2e(d2e.sender),
        .rs1_raddr, .rs2_raddr, .rs1_rdata, .rs2_rdata,
        .e2d_cmd, .e2d_branchtarget, .e2d_rd_write, .e2d_rd_waddr, .e2d_busy,
        .d2f_cmd, .d2f_branchtarget
    );

    cpu_regfile u_regfile (
        .clk, .rst_n, .rs1_raddr, .rs2_raddr, .rs1_rdata, .rs2_rdata,
        .rd_write, .rd_waddr, .rd_wdata
    );

    cpu_execute u_execute (
        .clk, .rst_n, .d2e(d2e.receiver),
        .e2d_cmd, .e2d_branchtarget, .e2d_rd_write, .e2d_rd_waddr, .e2d_busy,
        .rd_write, .rd_waddr, .rd_wdata,
        .retire_valid, .retire_pc, .retire_rd, .retire_wdata, .retire_trap
    );

endmodule

// File: cpu_execute.sv
/*
 * Execute stage
 * ALU, branch resolution, register writeback and retire reporting
 */
module cpu_execute
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    stage_if.receiver         d2e,
    output e2d_cmd_t          e2d_cmd,
    output logic [XLEN-1:0]   e2d_branchtarget,
    output logic              e2d_rd_write,
    output logic [REG_AW-1:0] e2d_rd_waddr,
    output logic              e2d_busy,
    output logic              rd_write,
    output logic [REG_AW-1:0] rd_waddr,
    output logic [XLEN-1:0]   rd_wdata,
    output logic              retire_valid,
    output logic [XLEN-1:0]   retire_pc,
    output logic [REG_AW-1:0] retire_rd,
    output logic [XLEN-1:0]   retire_wdata,
    output logic              retire_trap
);

    exec_pkt_t         pkt;
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   imm_i, imm_u, imm_b, imm_j;
    logic [XLEN-1:0]   alu_b, result, target;
    logic              legal, writes, taken, trap, wr, redirect, xfer;

    assign pkt    = d2e.payload;
    assign opcode = pkt.instr[6:0];
    assign funct3 = pkt.instr[14:12];
    assign funct7 = pkt.instr[31:25];
    assign rd     = pkt.instr[RD_LSB +: REG_AW];

    // Immediates by format
    assign imm_i = {{20{pkt.instr[31]}}, pkt.instr[31:20]};
    assign imm_u = {pkt.instr[31:12], 12'b0};
    assign imm_b = {{19{pkt.instr[31]}}, pkt.instr[31], pkt.instr[7],
                    pkt.instr[30:25], pkt.instr[11:8], 1'b0};
    assign imm_j = {{11{pkt.instr[31]}}, pkt.instr[31], pkt.instr[19:12],
                    pkt.instr[20], pkt.instr[30:21], 1'b0};
    assign alu_b = (opcode == OPC_OP) ? pkt.rs2_val : imm_i;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction decode and ALU
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        legal  = 1'b0;
        writes = 1'b0;
        taken  = 1'b0;
        result = '0;
        target = pkt.pc + imm_b;
        case (opcode)
            OPC_OP_IMM, OPC_OP: begin
                legal  = 1'b1;
                writes = 1'b1;
                case (funct3)
                    F3_ADD: result = (opcode == OPC_OP && funct7 == F7_SUB) ?
                                     pkt.rs1_val - alu_b : pkt.rs1_val + alu_b;
                    F3_XOR: result = pkt.rs1_val ^ alu_b;
                    F3_OR:  result = pkt.rs1_val | alu_b;
                    F3_AND: result = pkt.rs1_val & alu_b;
                    default: legal = 1'b0;
                endcase
                // Register form only knows funct7 zero, plus SUB
                if (opcode == OPC_OP && funct7 != '0 &&
                    !(funct7 == F7_SUB && funct3 == F3_ADD)) begin
                    legal = 1'b0;
                end
            end
            OPC_LUI: begin
                legal  = 1'b1;
                writes = 1'b1;
                result = imm_u;
            end
            OPC_BRANCH: begin
                legal = 1'b1;
                case (funct3)
                    F3_BEQ:  taken = (pkt.rs1_val == pkt.rs2_val);
                    F3_BNE:  taken = (pkt.rs1_val != pkt.rs2_val);
                    default: legal = 1'b0;
                endcase
            end
            OPC_JAL: begin
                legal  = 1'b1;
                writes = 1'b1;
                taken  = 1'b1;
                // Link address
                result = pkt.pc + XLEN'(4);
                target = pkt.pc + imm_j;
            end
            default: legal = 1'b0;
        endcase
    end

    // Fault or unknown encoding retires as a trap and falls through
    assign trap     = !legal || (pkt.resp != FRESP_OK);
    assign wr       = writes && !trap;
    assign redirect = d2e.valid && !trap && taken;
    assign xfer     = d2e.valid && d2e.ready;

    // Always ready, stalls come from decode only
    assign d2e.ready        = 1'b1;
    assign d2e.flush        = redirect;
    assign e2d_cmd          = redirect ? E2D_FLUSH : E2D_NONE;
    assign e2d_branchtarget = target;
    assign e2d_rd_write     = wr;
    assign e2d_rd_waddr     = rd;
    assign e2d_busy         = d2e.valid;

    // Register file takes the write on the transfer edge
    assign rd_write = xfer && wr;
    assign rd_waddr = rd;
    assign rd_wdata = result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= xfer;
        end
    end

    // Retire record, rd and data zero when nothing is written
    always_ff @(posedge clk) begin
        if (xfer) begin
            retire_pc    <= pkt.pc;
            retire_rd    <= wr ? rd : '0;
            retire_wdata <= (wr && rd != '0) ? result : '0;
            retire_trap  <= trap;
        end
    end

endmodule

// File: cpu_regfile.sv
/*
 * Integer register file, 31 writable registers
 * Two combinational read ports, one write port, x0 reads as zero
 */
module cpu_regfile
    import cpu_isa_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [REG_AW-1:0] rs1_raddr,
    input  logic [REG_AW-1:0] rs2_raddr,
    output logic [XLEN-1:0]   rs1_rdata,
    output logic [XLEN-1:0]   rs2_rdata,
    input  logic              rd_write,
    input  logic [REG_AW-1:0] rd_waddr,
    input  logic [XLEN-1:0]   rd_wdata
);

    // No storage for x0
    logic [XLEN-1:0] regs [1:(2**REG_AW)-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_write && (rd_waddr != '0)) begin
            regs[rd_waddr] <= rd_wdata;
        end
    end

    assign rs1_rdata = (rs1_raddr == '0) ? '0 : regs[rs1_raddr];
    assign rs2_rdata = (rs2_raddr == '0) ? '0 : regs[rs2_raddr];

endmodule

// File: cpu_decode.sv
/*
 * Decode stage
 * Reads the register file, stalls on writes still owed by execute and
 * passes flush and redirect on toward fetch
 */
module cpu_decode
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    output logic              busy,
    stage_if.receiver         f2d,
    stage_if.sender           d2e,
    output logic [REG_AW-1:0] rs1_raddr,
    output logic [REG_AW-1:0] rs2_raddr,
    input  logic [XLEN-1:0]   rs1_rdata,
    input  logic [XLEN-1:0]   rs2_rdata,
    input  e2d_cmd_t          e2d_cmd,
    input  logic [XLEN-1:0]   e2d_branchtarget,
    input  logic              e2d_rd_write,
    input  logic [REG_AW-1:0] e2d_rd_waddr,
    input  logic              e2d_busy,
    output d2f_cmd_t          d2f_cmd,
    output logic [XLEN-1:0]   d2f_branchtarget
);

    fetch_pkt_t in_pkt;
    exec_pkt_t  out_pkt;
    logic       out_valid;
    logic       flush_in;
    logic       hazard;
    logic       out_free;
    logic       take;

    assign in_pkt = f2d.payload;

    // Source fields, read even for formats without them
    assign rs1_raddr = in_pkt.instr[RS1_LSB +: REG_AW];
    assign rs2_raddr = in_pkt.instr[RS2_LSB +: REG_AW];

    ////////////////////////////////////////////////////////////////////////////
    // Hazard and acceptance
    ////////////////////////////////////////////////////////////////////////////

    // Execute writes a source this cycle, the read would be stale
    assign hazard = e2d_busy && e2d_rd_write && (e2d_rd_waddr != '0) &&
                    ((e2d_rd_waddr == rs1_raddr) || (e2d_rd_waddr == rs2_raddr));

    assign flush_in = (e2d_cmd == E2D_FLUSH);
    // Output register empty or leaving this cycle
    assign out_free = !out_valid || d2e.ready;
    assign f2d.ready = out_free && !hazard && !flush_in;
    assign take = f2d.valid && f2d.ready;

    // Redirect goes straight through to fetch
    assign f2d.flush        = flush_in;
    assign d2f_cmd          = flush_in ? D2F_BRANCH : D2F_NONE;
    assign d2f_branchtarget = e2d_branchtarget;

    assign d2e.valid   = out_valid;
    assign d2e.payload = out_pkt;
    assign busy        = f2d.valid || out_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (d2e.flush) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (d2e.ready) begin
            out_valid <= 1'b0;
        end
    end

    // Instruction plus operands, captured on acceptance
    always_ff @(posedge clk) begin
        if (take) begin
            out_pkt.instr   <= in_pkt.instr;
            out_pkt.pc      <= in_pkt.pc;
            out_pkt.resp    <= in_pkt.resp;
            out_pkt.rs1_val <= rs1_rdata;
            out_pkt.rs2_val <= rs2_rdata;
        end
    end

endmodule

// File: cpu_fetch.sv
/*
 * Fetch stage
 * Keeps the pc, issues one instruction-memory request at a time and
 * turns each response into a packet for decode
 */
module cpu_fetch
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    output logic            imem_req,
    output logic [XLEN-1:0] imem_addr,
    input  logic            imem_valid,
    input  logic [XLEN-1:0] imem_rdata,
    input  logic            imem_err,
    stage_if.sender         f2d,
    input  d2f_cmd_t        d2f_cmd,
    input  logic [XLEN-1:0] d2f_branchtarget
);

    logic [XLEN-1:0] pc;
    // Request sent, response not yet seen
    logic            outstanding;
    // Outstanding response belongs to the old path
    logic            drop;
    logic            pkt_valid;
    fetch_pkt_t      pkt;
    logic            redirect;
    logic            issue;
    logic            resp_keep;

    assign redirect = (d2f_cmd == D2F_BRANCH);
    // Next request only once the current packet leaves
    assign issue = !outstanding && (!pkt_valid || f2d.ready) && !redirect;
    assign resp_keep = imem_valid && outstanding && !drop && !f2d.flush;

    assign f2d.valid   = pkt_valid;
    assign f2d.payload = pkt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= '0;
            imem_req    <= 1'b0;
            imem_addr   <= '0;
            outstanding <= 1'b0;
            drop        <= 1'b0;
            pkt_valid   <= 1'b0;
        end else begin
            // Single-cycle request pulse
            imem_req <= issue;
            if (imem_valid) begin
                outstanding <= 1'b0;
                drop        <= 1'b0;
            end
            if (issue) begin
                outstanding <= 1'b1;
                imem_addr   <= pc;
                pc          <= pc + XLEN'(4);
            end
            // Redirect, old response still in flight gets discarded
            if (redirect) begin
                pc <= d2f_branchtarget;
                if (outstanding && !imem_valid) begin
                    drop <= 1'b1;
                end
            end
            if (f2d.flush) begin
                pkt_valid <= 1'b0;
            end else if (resp_keep) begin
                pkt_valid <= 1'b1;
            end else if (f2d.ready) begin
                pkt_valid <= 1'b0;
            end
        end
    end

    // Packet contents, pc taken from the request address
    always_ff @(posedge clk) begin
        if (resp_keep) begin
            pkt.instr <= imem_rdata;
            pkt.pc    <= imem_addr;
            pkt.resp  <= imem_err ? FRESP_FAULT : FRESP_OK;
        end
    end

endmodule

// File: stage_if.sv
/*
 * Valid/ready link between two pipeline stages
 * Payload type is set per instance, flush comes back from the receiver side
 */
interface stage_if #(
    parameter type payload_t = logic
);

    // Sender holds valid and payload until transfer or flush
    logic     valid;
    logic     ready;
    // Receiver side tells the sender to drop its packet
    logic     flush;
    payload_t payload;

    modport sender (
        output valid,
        output payload,
        input  ready,
        input  flush
    );

    modport receiver (
        input  valid,
        input  payload,
        output ready,
        output flush
    );

endinterface

// File: cpu_pipe_pkg.sv
/*
 * Pipeline types shared by fetch, decode and execute
 * Stage packets, inter-stage commands and fetch response codes
 */
package cpu_pipe_pkg;

    import cpu_isa_pkg::*;

    // Fetch response, fault marks a failed instruction access
    typedef enum logic [1:0] {
        FRESP_OK    = 2'b00,
        FRESP_FAULT = 2'b01
    } fetch_resp_t;

    ////////////////////////////////////////////////////////////////////////////
    // Stage packets
    ////////////////////////////////////////////////////////////////////////////

    // Fetch to decode, 66 bits
    typedef struct packed {
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
        fetch_resp_t     resp;
    } fetch_pkt_t;

    // Decode to execute, operands already read, 130 bits
    typedef struct packed {
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
        fetch_resp_t     resp;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
    } exec_pkt_t;

    // Redirect request toward fetch
    typedef enum logic {D2F_NONE, D2F_BRANCH} d2f_cmd_t;
    // Flush request from execute
    typedef enum logic {E2D_NONE, E2D_FLUSH} e2d_cmd_t;

endpackage

// File: cpu_isa_pkg.sv
/*
 * RV32I ISA constants for the integer core
 * Opcodes, funct codes, register field positions and the word width
 */
package cpu_isa_pkg;

    // Data and address width
    localparam int XLEN   = 32;
    // Register address width, 32 architectural registers
    localparam int REG_AW = 5;

    // Lowest bit of each register field in the instruction word
    localparam int RD_LSB  = 7;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;

    ////////////////////////////////////////////////////////////////////////////
    // Major opcodes of the supported subset
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // ALU funct3, shared by register and immediate forms
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // Branch funct3
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // funct7 that turns ADD into SUB
    localparam logic [6:0] F7_SUB = 7'b0100000;

endpackage
